// File: src/bus_pkg.sv
package bus_pkg;

    typedef logic [19:1] addr_t;       // word address, byte address bits 19 to 1
    typedef logic [15:0] data_t;
    typedef logic [1:0]  bytesel_t;    // bit 0 enables the low byte
    typedef logic [15:0] io_addr_t;    // I/O port byte address

    localparam io_addr_t leds_port     = 16'hfffe;
    localparam io_addr_t spi_data_port = 16'hfff0;
    localparam io_addr_t spi_ctrl_port = 16'hfff2;

    // clk cycles per SCLK half period, a full transfer takes 16 of these
    localparam int unsigned spi_half_period = 4;

    typedef enum logic [1:0] {
        arb_idle,
        arb_instr,
        arb_data
    } arb_state_t;

    typedef enum logic {
        spi_idle,
        spi_shift
    } spi_state_t;

endpackage

// File: src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  addr_t    instr_m_addr,
    input  logic     instr_m_access,
    output logic     instr_m_ack,
    output data_t    instr_m_data_in,

    input  addr_t    data_m_addr,
    input  data_t    data_m_data_out,
    input  logic     data_m_access,
    input  logic     data_m_wr_en,
    input  bytesel_t data_m_bytesel,
    output logic     data_m_ack,
    output data_t    data_m_data_in,

    output addr_t    q_m_addr,
    output data_t    q_m_data_out,
    output logic     q_m_access,
    output logic     q_m_wr_en,
    output bytesel_t q_m_bytesel,
    input  logic     q_m_ack,
    input  data_t    q_m_data_in
);

    arb_state_t state;
    arb_state_t state_next;
    logic       instr_turn;            // instruction master waited behind a data access

    always_comb begin
        state_next = state;
        unique case (state)
            arb_idle: begin
                if (instr_turn && instr_m_access)
                    state_next = arb_instr;
                else if (data_m_access)
                    state_next = arb_data;  // data wins a tie from a clean idle
                else if (instr_m_access)
                    state_next = arb_instr;
            end
            arb_instr,
            arb_data: begin
                if (q_m_ack)
                    state_next = arb_idle;
            end
            default: state_next = arb_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= arb_idle;
            instr_turn <= 1'b0;
        end else begin
            state <= state_next;
            if (state == arb_data && q_m_ack && instr_m_access)
                instr_turn <= 1'b1;
            else if (state == arb_idle && state_next == arb_instr)
                instr_turn <= 1'b0;
        end
    end

    assign q_m_access   = state != arb_idle;
    assign q_m_addr     = (state == arb_instr) ? instr_m_addr : data_m_addr;
    assign q_m_data_out = (state == arb_data) ? data_m_data_out : '0;
    assign q_m_wr_en    = (state == arb_data) && data_m_wr_en;
    assign q_m_bytesel  = (state == arb_instr) ? 2'b11 : data_m_bytesel;  // fetches are whole words

    // ack goes straight back to the owner in the same cycle
    assign instr_m_ack     = (state == arb_instr) && q_m_ack;
    assign data_m_ack      = (state == arb_data) && q_m_ack;
    assign instr_m_data_in = instr_m_ack ? q_m_data_in : '0;
    assign data_m_data_in  = data_m_ack ? q_m_data_in : '0;

endmodule

// File: src/io_decoder.sv
`timescale 1ns/1ps

module io_decoder
    import bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  d_io,
    input  logic  data_m_access,
    input  addr_t data_m_addr,
    output logic  leds_access,
    output logic  spi_access,
    input  logic  leds_ack,
    input  logic  spi_ack,
    input  data_t leds_data,
    input  data_t spi_data,
    output logic  io_ack,
    output data_t io_data
);

    io_addr_t io_port;
    logic     default_access;
    logic     default_ack;

    assign io_port = {data_m_addr[15:1], 1'b0};

    always_comb begin
        leds_access    = 1'b0;
        spi_access     = 1'b0;
        default_access = 1'b0;
        if (d_io && data_m_access) begin
            if (io_port == leds_port)
                leds_access = 1'b1;
            else if ({io_port[15:2], io_port[0]} == {spi_data_port[15:2], spi_data_port[0]})
                spi_access = 1'b1;     // data and control ports share all but bit 1
            else
                default_access = 1'b1;
        end
    end

    // unmapped ports still ack so the core never hangs on them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            default_ack <= 1'b0;
        else
            default_ack <= default_access && !default_ack;
    end

    assign io_ack  = leds_ack | spi_ack | default_ack;
    assign io_data = leds_data | spi_data;  // the default responder returns zero

endmodule

// File: src/leds_register.sv
`timescale 1ns/1ps

module leds_register
    import bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cs,
    input  logic       wr_en,
    input  bytesel_t   bytesel,
    input  data_t      wdata,
    output logic       ack,
    output data_t      rdata,
    output logic [7:0] leds
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack  <= 1'b0;
            leds <= 8'h00;
        end else begin
            ack <= cs && !ack;
            if (cs && !ack && wr_en && bytesel[0])
                leds <= wdata[7:0];    // only the low lane is backed by pins
        end
    end

    assign rdata = (ack && !wr_en) ? {8'h00, leds} : '0;

endmodule

// File: src/spi_ports.sv
`timescale 1ns/1ps

module spi_ports
    import bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cs,
    input  logic     wr_en,
    input  logic     reg_sel,         // address bit 1, high selects control
    input  bytesel_t bytesel,
    input  data_t    wdata,
    output logic     ack,
    output data_t    rdata,
    output logic     sclk,
    output logic     mosi,
    input  logic     miso,
    output logic     ncs
);

    spi_state_t state;
    logic [7:0] div_cnt;
    logic [3:0] half_cnt;              // counts the 16 SCLK half periods
    logic [7:0] shift_reg;
    logic [7:0] rx_data;
    logic       busy;
    logic       half_tick;
    logic       bus_write;
    logic       start;

    assign busy      = state == spi_shift;
    assign half_tick = busy && (div_cnt == 8'(spi_half_period - 1));
    assign bus_write = cs && !ack && wr_en;
    assign start     = bus_write && !reg_sel && bytesel[0] && !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= spi_idle;
            ack      <= 1'b0;
            div_cnt  <= 8'd0;
            half_cnt <= 4'd0;
            sclk     <= 1'b0;
            mosi     <= 1'b0;
            ncs      <= 1'b1;
        end else begin
            ack <= cs && !ack;

            if (bus_write && reg_sel && bytesel[1])
                ncs <= wdata[8];

            unique case (state)
                spi_idle: begin
                    if (start) begin
                        state    <= spi_shift;
                        div_cnt  <= 8'd0;
                        half_cnt <= 4'd0;
                        sclk     <= 1'b0;
                        mosi     <= wdata[7];  // first bit is set up before the first rising edge
                    end
                end
                spi_shift: begin
                    if (half_tick) begin
                        div_cnt  <= 8'd0;
                        half_cnt <= half_cnt + 4'd1;
                        sclk     <= !sclk;
                        if (half_cnt == 4'd15)
                            state <= spi_idle;
                        else if (sclk)
                            mosi <= shift_reg[7];  // falling half moves the next bit out
                    end else begin
                        div_cnt <= div_cnt + 8'd1;
                    end
                end
                default: state <= spi_idle;
            endcase
        end
    end

    // the same register shifts out on MOSI and in from MISO
    always_ff @(posedge clk) begin
        if (start)
            shift_reg <= wdata[7:0];
        else if (half_tick && !sclk)
            shift_reg <= {shift_reg[6:0], miso};

        if (half_tick && half_cnt == 4'd15)
            rx_data <= shift_reg;
    end

    always_comb begin
        rdata = '0;
        if (ack && !wr_en) begin
            if (reg_sel)
                rdata = {6'b000000, busy, ncs, 8'h00};
            else
                rdata = {8'h00, rx_data};
        end
    end

endmodule

// File: src/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top
    import bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  addr_t      instr_m_addr,
    input  logic       instr_m_access,
    output logic       instr_m_ack,
    output data_t      instr_m_data_in,

    input  addr_t      data_m_addr,
    input  data_t      data_m_data_out,
    input  logic       data_m_access,
    input  logic       data_m_wr_en,
    input  bytesel_t   data_m_bytesel,
    input  logic       d_io,
    output logic       data_m_ack,
    output data_t      data_m_data_in,

    output addr_t      q_m_addr,
    output data_t      q_m_data_out,
    output logic       q_m_access,
    output logic       q_m_wr_en,
    output bytesel_t   q_m_bytesel,
    input  logic       q_m_ack,
    input  data_t      q_m_data_in,

    output logic [7:0] leds,
    output logic       spi_sclk,
    output logic       spi_mosi,
    input  logic       spi_miso,
    output logic       spi_ncs
);

    logic  mem_ack;
    data_t mem_data;
    logic  io_ack;
    data_t io_data;
    logic  leds_access;
    logic  leds_ack;
    data_t leds_data;
    logic  spi_access;
    logic  spi_ack;
    data_t spi_data;

    assign data_m_ack     = d_io ? io_ack : mem_ack;
    assign data_m_data_in = d_io ? io_data : mem_data;

    mem_arbiter mem_arbiter_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .instr_m_addr    (instr_m_addr),
        .instr_m_access  (instr_m_access),
        .instr_m_ack     (instr_m_ack),
        .instr_m_data_in (instr_m_data_in),
        .data_m_addr     (data_m_addr),
        .data_m_data_out (data_m_data_out),
        .data_m_access   (data_m_access && !d_io),  // I/O accesses never reach memory
        .data_m_wr_en    (data_m_wr_en),
        .data_m_bytesel  (data_m_bytesel),
        .data_m_ack      (mem_ack),
        .data_m_data_in  (mem_data),
        .q_m_addr        (q_m_addr),
        .q_m_data_out    (q_m_data_out),
        .q_m_access      (q_m_access),
        .q_m_wr_en       (q_m_wr_en),
        .q_m_bytesel     (q_m_bytesel),
        .q_m_ack         (q_m_ack),
        .q_m_data_in     (q_m_data_in)
    );

    io_decoder io_decoder_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .d_io          (d_io),
        .data_m_access (data_m_access),
        .data_m_addr   (data_m_addr),
        .leds_access   (leds_access),
        .spi_access    (spi_access),
        .leds_ack      (leds_ack),
        .spi_ack       (spi_ack),
        .leds_data     (leds_data),
        .spi_data      (spi_data),
        .io_ack        (io_ack),
        .io_data       (io_data)
    );

    leds_register leds_register_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .cs      (leds_access),
        .wr_en   (data_m_wr_en),
        .bytesel (data_m_bytesel),
        .wdata   (data_m_data_out),
        .ack     (leds_ack),
        .rdata   (leds_data),
        .leds    (leds)
    );

    spi_ports spi_ports_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .cs      (spi_access),
        .wr_en   (data_m_wr_en),
        .reg_sel (data_m_addr[1]),
        .bytesel (data_m_bytesel),
        .wdata   (data_m_data_out),
        .ack     (spi_ack),
        .rdata   (spi_data),
        .sclk    (spi_sclk),
        .mosi    (spi_mosi),
        .miso    (spi_miso),
        .ncs     (spi_ncs)
    );

endmodule

// File: bench/soc_bus_chk.sv
`timescale 1ns/1ps

module soc_bus_chk (
    input logic clk,
    input logic rst_n,
    input logic instr_m_ack,
    input logic data_m_ack,
    input logic q_m_access,
    input logic q_m_ack
);

    // acks never last longer than one cycle
    a_instr_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        instr_m_ack |=> !instr_m_ack) else $error("instr_m_ack held high");
    a_data_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        data_m_ack |=> !data_m_ack) else $error("data_m_ack held high");
    a_q_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        q_m_ack |=> !q_m_ack) else $error("q_m_ack held high");

    a_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
        !(instr_m_ack && data_m_ack)) else $error("both masters acked together");

    a_q_hold: assert property (@(posedge clk) disable iff (!rst_n)
        q_m_access && !q_m_ack |=> q_m_access) else $error("q_m_access dropped early");

    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !q_m_access && !instr_m_ack && !data_m_ack)
        else $error("bus active right after reset");

endmodule

bind soc_bus_top soc_bus_chk soc_bus_chk_i (.*);

// File: bench/tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus
    import bus_pkg::*;
();

    localparam int n_mem   = 40;
    localparam int n_pairs = 16;
    localparam int n_leds  = 12;
    localparam int n_spi   = 6;
    localparam int n_unmap = 8;
    // every bus access fits in 12 cycles, SPI polling adds one poll beyond the transfer
    localparam int cycle_limit = (2 * n_mem + 2 * n_pairs + 2 * n_leds + n_unmap + 2) * 12
                                 + n_spi * (16 * spi_half_period + 40) + 100;

    logic       clk;
    logic       rst_n;
    addr_t      instr_m_addr;
    logic       instr_m_access;
    logic       instr_m_ack;
    data_t      instr_m_data_in;
    addr_t      data_m_addr;
    data_t      data_m_data_out;
    logic       data_m_access;
    logic       data_m_wr_en;
    bytesel_t   data_m_bytesel;
    logic       d_io;
    logic       data_m_ack;
    data_t      data_m_data_in;
    addr_t      q_m_addr;
    data_t      q_m_data_out;
    logic       q_m_access;
    logic       q_m_wr_en;
    bytesel_t   q_m_bytesel;
    logic       q_m_ack;
    data_t      q_m_data_in;
    logic [7:0] leds;
    logic       spi_sclk;
    logic       spi_mosi;
    logic       spi_miso;
    logic       spi_ncs;

    data_t       mem [256];
    data_t       ref_mem [256];
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          cycles;
    int          mem_accesses;
    logic        mem_busy;
    int          wait_left;
    logic [7:0]  m_idx;
    data_t       m_wdata;
    logic        m_wr;
    bytesel_t    m_bs;
    time         instr_ack_time;
    time         data_ack_time;
    logic [7:0]  mosi_bits;
    int          sclk_rises;

    soc_bus_top dut_i (.*);

    assign spi_miso = spi_mosi;        // loopback, so every byte comes back unchanged

    always #20 clk = ~clk;

    function automatic logic [31:0] rnd(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic data_t fill_word(input int i);
        return data_t'(i * 16'h9e37) ^ 16'h5a5a;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    // memory on the q bus with 0 to 3 wait cycles before each ack
    always @(posedge clk) begin
        if (q_m_ack) begin
            #2;
            q_m_ack = 1'b0;
            q_m_data_in = '0;
        end else if (q_m_access) begin
            if (!mem_busy) begin
                mem_busy = 1'b1;
                wait_left = int'(rnd(2));
            end
            if (wait_left == 0) begin
                m_idx = q_m_addr[8:1];
                m_wdata = q_m_data_out;
                m_wr = q_m_wr_en;
                m_bs = q_m_bytesel;
                #2;
                q_m_data_in = mem[m_idx];
                if (m_wr) begin
                    if (m_bs[0])
                        mem[m_idx][7:0] = m_wdata[7:0];
                    if (m_bs[1])
                        mem[m_idx][15:8] = m_wdata[15:8];
                end
                mem_accesses++;
                q_m_ack = 1'b1;
                mem_busy = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

    // mode 0 slave view, each bit is taken on the rising SCLK
    always @(posedge spi_sclk) begin
        mosi_bits = {mosi_bits[6:0], spi_mosi};
        sclk_rises++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, a bus access never completed", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic data_access(input logic io, input logic we, input addr_t a,
                               input bytesel_t bs, input data_t wd, output data_t rd);
        @(posedge clk);
        #2;
        d_io = io;
        data_m_wr_en = we;
        data_m_addr = a;
        data_m_bytesel = bs;
        data_m_data_out = wd;
        data_m_access = 1'b1;
        do
            @(posedge clk);
        while (!data_m_ack);
        rd = data_m_data_in;
        data_ack_time = $time;
        #2;
        data_m_access = 1'b0;
        d_io = 1'b0;
    endtask

    task automatic instr_fetch(input addr_t a, output data_t rd);
        @(posedge clk);
        #2;
        instr_m_addr = a;
        instr_m_access = 1'b1;
        do
            @(posedge clk);
        while (!instr_m_ack);
        rd = instr_m_data_in;
        instr_ack_time = $time;
        #2;
        instr_m_access = 1'b0;
    endtask

    task automatic ref_write(input logic [7:0] i, input bytesel_t bs, input data_t wd);
        if (bs[0])
            ref_mem[i][7:0] = wd[7:0];
        if (bs[1])
            ref_mem[i][15:8] = wd[15:8];
    endtask

    function automatic addr_t io_addr(input io_addr_t port);
        return {4'h0, port[15:1]};
    endfunction

    initial begin
        logic [7:0] idx;
        logic [7:0] fidx;
        logic [7:0] leds_exp;
        bytesel_t   bs;
        data_t      wd;
        data_t      rd;
        data_t      fd;
        logic       we;
        int         acc_before;
        int         rises_before;
        io_addr_t   port;

        clk = 1'b0;
        rst_n = 1'b0;
        instr_m_addr = '0;
        instr_m_access = 1'b0;
        data_m_addr = '0;
        data_m_data_out = '0;
        data_m_access = 1'b0;
        data_m_wr_en = 1'b0;
        data_m_bytesel = '0;
        d_io = 1'b0;
        q_m_ack = 1'b0;
        q_m_data_in = '0;
        lfsr = 32'hf229c85f;
        errors = 0;
        checks = 0;
        cycles = 0;
        mem_accesses = 0;
        mem_busy = 1'b0;
        wait_left = 0;
        leds_exp = 8'h00;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        for (int i = 0; i < n_mem; i++) begin
            idx = 8'(rnd(8));
            bs = 2'(rnd(2));
            wd = 16'(rnd(16));
            data_access(1'b0, 1'b1, {11'h0, idx}, bs, wd, rd);
            ref_write(idx, bs, wd);
        end
        for (int i = 0; i < n_mem; i++) begin
            idx = 8'(rnd(8));
            data_access(1'b0, 1'b0, {11'h0, idx}, 2'b11, '0, rd);
            check_value(rd, ref_mem[idx], "memory read");
        end

        // data and fetch start in the same cycle and the data master goes first
        for (int i = 0; i < n_pairs; i++) begin
            idx = 8'(rnd(8));
            fidx = 8'(rnd(8));
            we = 1'(rnd(1));
            bs = 2'(rnd(2));
            wd = 16'(rnd(16));
            fork
                data_access(1'b0, we, {11'h0, idx}, bs, wd, rd);
                instr_fetch({11'h0, fidx}, fd);
            join
            if (we)
                ref_write(idx, bs, wd);
            else
                check_value(rd, ref_mem[idx], "data read beside fetch");
            check_value(fd, ref_mem[fidx], "instruction fetch");
            check_value(data_ack_time < instr_ack_time, 1, "data master granted first");
        end

        for (int i = 0; i < n_leds; i++) begin
            bs = 2'(rnd(2));
            wd = 16'(rnd(16));
            data_access(1'b1, 1'b1, io_addr(leds_port), bs, wd, rd);
            if (bs[0])
                leds_exp = wd[7:0];
            check_value(leds, leds_exp, "leds pins");
            data_access(1'b1, 1'b0, io_addr(leds_port), 2'b11, '0, rd);
            check_value(rd, {8'h00, leds_exp}, "leds readback");
        end

        check_value(spi_ncs, 1'b1, "ncs high after reset");
        data_access(1'b1, 1'b1, io_addr(spi_ctrl_port), 2'b11, '0, rd);
        check_value(spi_ncs, 1'b0, "ncs after control write");
        for (int i = 0; i < n_spi; i++) begin
            wd = {8'h00, 8'(rnd(8))};
            rises_before = sclk_rises;
            data_access(1'b1, 1'b1, io_addr(spi_data_port), 2'b01, wd, rd);
            data_access(1'b1, 1'b0, io_addr(spi_ctrl_port), 2'b11, '0, rd);
            check_value(rd[9], 1'b1, "spi busy after start");
            while (rd[9])
                data_access(1'b1, 1'b0, io_addr(spi_ctrl_port), 2'b11, '0, rd);
            check_value(rd[8], 1'b0, "spi ncs readback");
            check_value(sclk_rises - rises_before, 8, "sclk rising edges per byte");
            check_value(mosi_bits, wd[7:0], "mosi bits msb first");
            check_value(spi_sclk, 1'b0, "sclk idle low");
            data_access(1'b1, 1'b0, io_addr(spi_data_port), 2'b11, '0, rd);
            check_value(rd, wd, "spi received byte");
        end

        acc_before = mem_accesses;
        for (int i = 0; i < n_unmap; i++) begin
            port = {1'b0, 14'(rnd(14)), 1'b0};   // top bit clear keeps it off the map
            data_access(1'b1, 1'b0, io_addr(port), 2'b11, '0, rd);
            check_value(rd, 16'h0000, "unmapped port read");
        end
        check_value(mem_accesses, acc_before, "memory bus idle during unmapped reads");
        check_value(leds, leds_exp, "leds untouched by unmapped reads");
        for (int i = 0; i < 256; i++)
            check_value(mem[i], ref_mem[i], "final memory contents");

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: flist.f
src/bus_pkg.sv
src/mem_arbiter.sv
src/io_decoder.sv
src/leds_register.sv
src/spi_ports.sv
src/soc_bus_top.sv
bench/soc_bus_chk.sv
bench/tb_soc_bus.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_bus
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(BUILD_DIR)
